// File: test/decode_trace.txt
# W reg(dec) value(hex) on_capture(0 now, 1 with next I)
# I name pc instr op rs_val rt_val imm target dest(dec) wr_en reserved
W 1 11111111 0
W 2 22222222 0
W 3 fffffff0 0
W 0 deadbeef 0
I add_r 00400000 00222020 ADD 11111111 22222222 00000000 00000000 4 1 0
I addu_r 00400004 00412821 ADDU 22222222 11111111 00000000 00000000 5 1 0
I sub_r 00400008 00613022 SUB fffffff0 11111111 00000000 00000000 6 1 0
I subu_r0 0040000c 00603823 SUBU fffffff0 00000000 00000000 00000000 7 1 0
I slt_r 00400010 0023402a SLT 11111111 fffffff0 00000000 00000000 8 1 0
W 2 0000abcd 1
I sltu_wt 00400014 0041482b SLTU 0000abcd 11111111 00000000 00000000 9 1 0
I addi_neg 00400018 202afff8 ADD 11111111 00000000 fffffff8 00000000 10 1 0
I andi_zx 0040001c 306b8001 AND fffffff0 00000000 00008001 00000000 11 1 0
I xori 00400020 382c1234 XOR 11111111 00000000 00001234 00000000 12 1 0
I lui 00400024 3c0dbeef LUI 00000000 00000000 beef0000 00000000 13 1 0
I beq 00400028 10220004 BEQ 11111111 0000abcd 00000004 0040003c 0 0 0
I bne_back 0040002c 1460fffe BNE fffffff0 00000000 fffffffe 00400028 0 0 0
I bgez 00400030 04210010 BGEZ 11111111 11111111 00000010 00400074 0 0 0
I bltzal 00400034 0470ffff BLTZAL fffffff0 00000000 ffffffff 00400034 31 1 0
I bgtz 00400038 1c400100 BGTZ 0000abcd 00000000 00000100 0040043c 0 0 0
I blez_far 0040003c 18008000 BLEZ 00000000 00000000 ffff8000 003e0040 0 0 0
I j 00400040 08100010 J 00000000 00000000 00000000 00400040 0 0 0
I jal_hi bfc00100 0c000040 JAL 00000000 00000000 00000000 b0000100 31 1 0
W 1 5a5a5a5a 0
I lw 00400048 8c2efffc LW 5a5a5a5a 00000000 fffffffc 00000000 14 1 0
I sb 0040004c a0610007 SB fffffff0 5a5a5a5a 00000007 00000000 0 0 0
I mfc0 00400050 40016000 MFC0 00000000 5a5a5a5a 00000000 00000000 1 1 0
I mtc0 00400054 40826000 MTC0 00000000 0000abcd 00000000 00000000 0 0 0
I eret 00400058 42000018 ERET 00000000 00000000 00000000 00000000 0 0 0
I bad_op 0040005c fc220000 ILLEGAL 5a5a5a5a 0000abcd 00000000 00000000 0 0 1
I bad_funct 00400060 0022183f ILLEGAL 5a5a5a5a 0000abcd 00000000 00000000 0 0 1
I bad_regimm 00400064 04050010 ILLEGAL 00000000 00000000 00000000 00000000 0 0 1
I bad_cop0 00400068 41000000 ILLEGAL 00000000 00000000 00000000 00000000 0 0 1

// File: filelist.f
+incdir+hdl
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/mips_decode_top.sv
test/tb_mips_decode.sv

// File: Bender.yml
package:
  name: mips_decode

export_include_dirs:
  - hdl

sources:
  - target: rtl
    include_dirs:
      - hdl
    files:
      - hdl/mips_isa_pkg.sv
      - hdl/mips_pipe_pkg.sv
      - hdl/instr_decoder.sv
      - hdl/reg_file.sv
      - hdl/decode_stage.sv
      - hdl/mips_decode_top.sv
  - target: test
    files:
      - test/tb_mips_decode.sv

// File: test/tb_mips_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_decode
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       in_req;
    word_t      in_instr;
    word_t      in_pc;
    logic       in_ack;
    logic       wb_we;
    reg_addr_t  wb_addr;
    word_t      wb_data;
    logic       out_req;
    logic       out_ack;
    mips_op_t   out_op;
    word_t      out_rs_val;
    word_t      out_rt_val;
    word_t      out_imm;
    word_t      out_target;
    reg_addr_t  out_dest;
    logic       out_wr_en;
    logic       out_reserved;
    word_t      out_pc;

    // trace steps in file order, W entries and I entries kept apart
    bit         step_w[$];
    int         step_idx[$];
    reg_addr_t  w_addr[$];
    word_t      w_data[$];
    bit         w_sync[$];
    string      t_name[$];
    word_t      t_pc[$];
    word_t      t_instr[$];
    mips_op_t   t_op[$];
    word_t      t_rs[$];
    word_t      t_rt[$];
    word_t      t_imm[$];
    word_t      t_target[$];
    reg_addr_t  t_dest[$];
    logic       t_wr[$];
    logic       t_res[$];

    integer     seed;
    int         err_count;
    int         test_errs;
    int         n_pass;
    int         n_fail;
    int         sent;
    int         captured;
    int         retired;
    int         cycles;
    int         limit;
    bit         done;
    bit         ack_seen;
    bit         trace_ok;

    mips_decode_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_req       (in_req),
        .in_instr     (in_instr),
        .in_pc        (in_pc),
        .in_ack       (in_ack),
        .wb_we        (wb_we),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .out_op       (out_op),
        .out_rs_val   (out_rs_val),
        .out_rt_val   (out_rt_val),
        .out_imm      (out_imm),
        .out_target   (out_target),
        .out_dest     (out_dest),
        .out_wr_en    (out_wr_en),
        .out_reserved (out_reserved),
        .out_pc       (out_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
    end

    initial begin
        wait (limit > 0);
        while (!done && cycles < limit) @(negedge clk);
        if (!done) begin
            $display("timeout: run stalled after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // every rise of in_ack is a capture and needs an empty slot
    always @(negedge clk) begin
        if (rst_n && in_ack && !ack_seen) begin
            if (captured != retired) begin
                $display("in_ack rose while the output slot still held an instruction");
                err_count++;
            end
            captured++;
        end
        ack_seen = in_ack;
    end

    function automatic bit op_from_name(input string s, output mips_op_t op);
        mips_op_t o;
        o = o.first();
        op = ILLEGAL;
        for (int k = 0; k < o.num(); k++) begin
            if (o.name() == s) begin
                op = o;
                return 1'b1;
            end
            o = o.next();
        end
        return 1'b0;
    endfunction

    task automatic read_trace(output bit ok);
        int         fd;
        int         code;
        string      tag;
        string      line;
        string      name;
        string      op_name;
        int         a;
        int         s;
        int         dest;
        int         wr;
        int         res;
        word_t      d;
        word_t      pc;
        word_t      instr;
        word_t      rs;
        word_t      rt;
        word_t      imm;
        word_t      tgt;
        mips_op_t   op;
        ok = 1'b0;
        fd = $fopen("test/decode_trace.txt", "r");
        if (fd == 0) begin
            return;
        end
        ok = 1'b1;
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                code = $fgets(line, fd);
            end else if (tag == "W") begin
                code = $fscanf(fd, "%d %h %d", a, d, s);
                if (code != 3) begin
                    ok = 1'b0;
                end
                step_w.push_back(1'b1);
                step_idx.push_back(w_addr.size());
                w_addr.push_back(reg_addr_t'(a));
                w_data.push_back(d);
                w_sync.push_back(s != 0);
            end else if (tag == "I") begin
                code = $fscanf(fd, "%s %h %h %s %h %h %h %h %d %d %d", name, pc, instr,
                    op_name, rs, rt, imm, tgt, dest, wr, res);
                if (code != 11) begin
                    ok = 1'b0;
                end
                if (!op_from_name(op_name, op)) begin
                    $display("unknown operation %s in trace", op_name);
                    ok = 1'b0;
                end
                step_w.push_back(1'b0);
                step_idx.push_back(t_name.size());
                t_name.push_back(name);
                t_pc.push_back(pc);
                t_instr.push_back(instr);
                t_op.push_back(op);
                t_rs.push_back(rs);
                t_rt.push_back(rt);
                t_imm.push_back(imm);
                t_target.push_back(tgt);
                t_dest.push_back(reg_addr_t'(dest));
                t_wr.push_back(wr != 0);
                t_res.push_back(res != 0);
            end else begin
                $display("unknown trace line tag %s", tag);
                ok = 1'b0;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_op(input string test, input mips_op_t exp, input mips_op_t act);
        if (act !== exp) begin
            $display("Mismatch %s op: expected %s actual %s", test, exp.name(), act.name());
            test_errs++;
        end
    endtask

    task automatic check_word(input string test, input string field, input word_t exp,
                              input word_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %h actual %h", test, field, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_reg(input string test, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("Mismatch %s dest: expected %0d actual %0d", test, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string test, input string field, input logic exp,
                              input logic act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %b actual %b", test, field, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_result(input int k);
        test_errs = 0;
        check_word(t_name[k], "pc", t_pc[k], out_pc);
        check_op(t_name[k], t_op[k], out_op);
        check_word(t_name[k], "rs_val", t_rs[k], out_rs_val);
        check_word(t_name[k], "rt_val", t_rt[k], out_rt_val);
        check_word(t_name[k], "imm", t_imm[k], out_imm);
        check_word(t_name[k], "target", t_target[k], out_target);
        check_reg(t_name[k], t_dest[k], out_dest);
        check_flag(t_name[k], "wr_en", t_wr[k], out_wr_en);
        check_flag(t_name[k], "reserved", t_res[k], out_reserved);
        if (test_errs == 0) begin
            n_pass++;
            $display("test %s ok", t_name[k]);
        end else begin
            n_fail++;
            $display("test %s failed with %0d mismatches", t_name[k], test_errs);
        end
    endtask

    task automatic write_reg(input reg_addr_t a, input word_t d);
        @(posedge clk);
        wb_we   <= 1'b1;
        wb_addr <= a;
        wb_data <= d;
        @(posedge clk);
        wb_we   <= 1'b0;
    endtask

    // fetch side of the four-phase link, optionally with a write on the capture edge
    task automatic send_instr(input int k, input bit wt, input reg_addr_t wa, input word_t wd);
        if (wt) begin
            // empty stage, so capture follows the raise by one edge
            while (retired < sent) @(negedge clk);
            @(posedge clk);
        end
        @(posedge clk);
        in_req   <= 1'b1;
        in_instr <= t_instr[k];
        in_pc    <= t_pc[k];
        if (wt) begin
            wb_we   <= 1'b1;
            wb_addr <= wa;
            wb_data <= wd;
            @(posedge clk);
            wb_we   <= 1'b0;
        end
        @(negedge clk);
        if (wt && !in_ack) begin
            $display("%s was not captured on the edge of its register write", t_name[k]);
            err_count++;
        end
        while (!in_ack) @(negedge clk);
        if (!out_req) begin
            $display("out_req was not raised at the capture edge of %s", t_name[k]);
            err_count++;
        end
        sent++;
        @(posedge clk);
        in_req <= 1'b0;
        @(negedge clk);
        while (in_ack) @(negedge clk);
    endtask

    task automatic run_fetch();
        bit         pend;
        reg_addr_t  pa;
        word_t      pd;
        pend = 1'b0;
        pa   = '0;
        pd   = '0;
        for (int s = 0; s < step_w.size(); s++) begin
            if (step_w[s] && w_sync[step_idx[s]]) begin
                pend = 1'b1;
                pa   = w_addr[step_idx[s]];
                pd   = w_data[step_idx[s]];
            end else if (step_w[s]) begin
                write_reg(w_addr[step_idx[s]], w_data[step_idx[s]]);
            end else begin
                send_instr(step_idx[s], pend, pa, pd);
                pend = 1'b0;
            end
        end
    endtask

    // execute side with random back-pressure
    task automatic run_execute();
        int delay;
        for (int k = 0; k < t_name.size(); k++) begin
            @(negedge clk);
            while (!out_req) @(negedge clk);
            check_result(k);
            delay = $unsigned($random(seed)) % 4;
            repeat (delay) @(posedge clk);
            @(posedge clk);
            out_ack <= 1'b1;
            @(negedge clk);
            while (out_req) @(negedge clk);
            @(posedge clk);
            out_ack <= 1'b0;
            // slot is empty once the low ack has been seen
            @(posedge clk);
            @(posedge clk);
            retired++;
        end
    endtask

    initial begin
        seed     = 91819;
        rst_n    = 1'b0;
        in_req   = 1'b0;
        in_instr = '0;
        in_pc    = '0;
        wb_we    = 1'b0;
        wb_addr  = '0;
        wb_data  = '0;
        out_ack  = 1'b0;
        done     = 1'b0;
        limit    = 0;
        read_trace(trace_ok);
        if (!trace_ok) begin
            $display("trace file test/decode_trace.txt could not be read");
            $display(">>> FAIL");
            $finish;
        end else begin
            limit = 20 * step_w.size() + 100;
            repeat (10) @(posedge clk);
            rst_n <= 1'b1;
            fork
                run_fetch();
                run_execute();
            join
            done = 1'b1;
            if (captured != t_name.size()) begin
                $display("saw %0d captures for %0d instructions", captured, t_name.size());
                err_count++;
            end
            $display("summary: %0d passed, %0d failed, %0d handshake errors",
                n_pass, n_fail, err_count);
            if (err_count == 0 && n_fail == 0 && n_pass == t_name.size()) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mips_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_decode_top
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_req,
    input  word_t       in_instr,
    input  word_t       in_pc,
    output logic        in_ack,
    input  logic        wb_we,
    input  reg_addr_t   wb_addr,
    input  word_t       wb_data,
    output logic        out_req,
    input  logic        out_ack,
    output mips_op_t    out_op,
    output word_t       out_rs_val,
    output word_t       out_rt_val,
    output word_t       out_imm,
    output word_t       out_target,
    output reg_addr_t   out_dest,
    output logic        out_wr_en,
    output logic        out_reserved,
    output word_t       out_pc
);

    // read port wiring between stage and register file
    reg_addr_t  rs_addr;
    reg_addr_t  rt_addr;
    word_t      rs_data;
    word_t      rt_data;

    decode_stage u_decode_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_req       (in_req),
        .in_instr     (in_instr),
        .in_pc        (in_pc),
        .in_ack       (in_ack),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .out_op       (out_op),
        .out_rs_val   (out_rs_val),
        .out_rt_val   (out_rt_val),
        .out_imm      (out_imm),
        .out_target   (out_target),
        .out_dest     (out_dest),
        .out_wr_en    (out_wr_en),
        .out_reserved (out_reserved),
        .out_pc       (out_pc),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .rs_data      (rs_data),
        .rt_data      (rt_data)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb_we   (wb_we),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_req,
    input  word_t       in_instr,
    input  word_t       in_pc,
    output logic        in_ack,
    output logic        out_req,
    input  logic        out_ack,
    output mips_op_t    out_op,
    output word_t       out_rs_val,
    output word_t       out_rt_val,
    output word_t       out_imm,
    output word_t       out_target,
    output reg_addr_t   out_dest,
    output logic        out_wr_en,
    output logic        out_reserved,
    output word_t       out_pc,
    output reg_addr_t   rs_addr,
    output reg_addr_t   rt_addr,
    input  word_t       rs_data,
    input  word_t       rt_data
);

    instr_u     in_word;
    mips_op_t   dec_op;
    imm_kind_t  dec_imm_kind;
    tgt_kind_t  dec_tgt_kind;
    reg_addr_t  dec_dest;
    logic       dec_wr_en;
    logic       dec_reserved;
    logic       slot_full;
    logic       capture;
    word_t      sext_imm;
    word_t      pc_plus4;
    word_t      imm_ext;
    word_t      target;

    assign in_word = in_instr;
    assign rs_addr = in_word.r.rs;
    assign rt_addr = in_word.r.rt;

    instr_decoder u_instr_decoder (
        .instr      (in_word),
        .op         (dec_op),
        .imm_kind   (dec_imm_kind),
        .tgt_kind   (dec_tgt_kind),
        .dest       (dec_dest),
        .wr_en      (dec_wr_en),
        .reserved   (dec_reserved)
    );

    assign sext_imm = {{16{in_word.i.imm16[15]}}, in_word.i.imm16};
    assign pc_plus4 = in_pc + 32'd4;

    always_comb begin
        case (dec_imm_kind)
            IMM_SIGN:   imm_ext = sext_imm;
            IMM_ZERO:   imm_ext = {16'h0000, in_word.i.imm16};
            IMM_UPPER:  imm_ext = {in_word.i.imm16, 16'h0000};
            default:    imm_ext = '0;
        endcase
    end

    always_comb begin
        case (dec_tgt_kind)
            TGT_BRANCH: target = pc_plus4 + {sext_imm[29:0], 2'b00};
            TGT_JUMP:   target = {pc_plus4[31:28], in_word.j.index26, 2'b00};
            default:    target = '0;
        endcase
    end

    // accept only into an empty slot, one word at a time
    assign capture = in_req && !in_ack && !slot_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack    <= 1'b0;
            out_req   <= 1'b0;
            slot_full <= 1'b0;
        end else if (capture) begin
            in_ack    <= 1'b1;
            out_req   <= 1'b1;
            slot_full <= 1'b1;
        end else begin
            if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end
            // execute has taken it; wait for its ack to fall
            if (out_req && out_ack) begin
                out_req <= 1'b0;
            end else if (slot_full && !out_req && !out_ack) begin
                slot_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            out_op       <= dec_op;
            out_rs_val   <= rs_data;
            out_rt_val   <= rt_data;
            out_imm      <= imm_ext;
            out_target   <= target;
            out_dest     <= dec_dest;
            out_wr_en    <= dec_wr_en;
            out_reserved <= dec_reserved;
            out_pc       <= in_pc;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_req && !out_ack) |=> $stable({out_op, out_rs_val, out_rt_val, out_imm,
            out_target, out_dest, out_wr_en, out_reserved, out_pc}));

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import mips_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  reg_addr_t   rs_addr,
    input  reg_addr_t   rt_addr,
    output word_t       rs_data,
    output word_t       rt_data,
    input  logic        wb_we,
    input  reg_addr_t   wb_addr,
    input  word_t       wb_data
);

    // r0 is not stored
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // zero register, then write-through, then stored value
    function automatic word_t read_port(input reg_addr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wb_we && wb_addr == addr) begin
            val = wb_data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    a_zero_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((rs_addr != '0) || (rs_data == '0)) && ((rt_addr != '0) || (rt_data == '0)));

endmodule

`default_nettype wire

// File: hdl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module instr_decoder
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
(
    input  instr_u      instr,
    output mips_op_t    op,
    output imm_kind_t   imm_kind,
    output tgt_kind_t   tgt_kind,
    output reg_addr_t   dest,
    output logic        wr_en,
    output logic        reserved
);

    logic is_rtype;
    assign is_rtype = (instr.r.op == `OP_RT);

    // opcode first, then funct / rt / rs sub-decode
    always_comb begin
        op = ILLEGAL;
        case (instr.r.op)
            `OP_ADDI:   op = ADD;
            `OP_ADDIU:  op = ADDU;
            `OP_SLTI:   op = SLT;
            `OP_SLTIU:  op = SLTU;
            `OP_ANDI:   op = AND;
            `OP_LUI:    op = LUI;
            `OP_ORI:    op = OR;
            `OP_XORI:   op = XOR;
            `OP_BEQ:    op = BEQ;
            `OP_BNE:    op = BNE;
            `OP_BGEZ: begin
                case (instr.i.rt)
                    `B_BGEZ:    op = BGEZ;
                    `B_BLTZ:    op = BLTZ;
                    `B_BGEZAL:  op = BGEZAL;
                    `B_BLTZAL:  op = BLTZAL;
                    default:    op = ILLEGAL;
                endcase
            end
            `OP_BGTZ:   op = BGTZ;
            `OP_BLEZ:   op = BLEZ;
            `OP_J:      op = J;
            `OP_JAL:    op = JAL;
            `OP_LB:     op = LB;
            `OP_LBU:    op = LBU;
            `OP_LH:     op = LH;
            `OP_LHU:    op = LHU;
            `OP_LW:     op = LW;
            `OP_SB:     op = SB;
            `OP_SH:     op = SH;
            `OP_SW:     op = SW;
            `OP_ERET: begin
                case (instr.r.rs)
                    `C_ERET:    op = ERET;
                    `C_MFC0:    op = MFC0;
                    `C_MTC0:    op = MTC0;
                    default:    op = ILLEGAL;
                endcase
            end
            `OP_RT: begin
                case (instr.r.funct)
                    `F_ADD:     op = ADD;
                    `F_ADDU:    op = ADDU;
                    `F_SUB:     op = SUB;
                    `F_SUBU:    op = SUBU;
                    `F_SLT:     op = SLT;
                    `F_SLTU:    op = SLTU;
                    default:    op = ILLEGAL;
                endcase
            end
            default:    op = ILLEGAL;
        endcase
    end

    // control follows from the decoded op
    always_comb begin
        imm_kind = IMM_NONE;
        tgt_kind = TGT_NONE;
        dest     = '0;
        wr_en    = 1'b0;
        case (op)
            ADD, ADDU, SLT, SLTU: begin
                wr_en    = 1'b1;
                dest     = is_rtype ? instr.r.rd : instr.i.rt;
                imm_kind = is_rtype ? IMM_NONE : IMM_SIGN;
            end
            SUB, SUBU: begin
                wr_en = 1'b1;
                dest  = instr.r.rd;
            end
            // only the immediate forms reach here
            AND, OR, XOR: begin
                wr_en    = 1'b1;
                dest     = instr.i.rt;
                imm_kind = IMM_ZERO;
            end
            LUI: begin
                wr_en    = 1'b1;
                dest     = instr.i.rt;
                imm_kind = IMM_UPPER;
            end
            BEQ, BNE, BGEZ, BLTZ, BGTZ, BLEZ: begin
                imm_kind = IMM_SIGN;
                tgt_kind = TGT_BRANCH;
            end
            BGEZAL, BLTZAL: begin
                wr_en    = 1'b1;
                dest     = reg_addr_t'(`LINK_REG);
                imm_kind = IMM_SIGN;
                tgt_kind = TGT_BRANCH;
            end
            J:      tgt_kind = TGT_JUMP;
            JAL: begin
                wr_en    = 1'b1;
                dest     = reg_addr_t'(`LINK_REG);
                tgt_kind = TGT_JUMP;
            end
            LB, LBU, LH, LHU, LW: begin
                wr_en    = 1'b1;
                dest     = instr.i.rt;
                imm_kind = IMM_SIGN;
            end
            SB, SH, SW: imm_kind = IMM_SIGN;
            MFC0: begin
                wr_en = 1'b1;
                dest  = instr.i.rt;
            end
            default: begin
                // MTC0, ERET and ILLEGAL write nothing
                wr_en = 1'b0;
            end
        endcase
    end

    assign reserved = (op == ILLEGAL);

    // sampled on each new word, so checks the settled outputs of the last one
    a_reserved_no_write: assert property (@(instr) reserved |-> !wr_en);

endmodule

`default_nettype wire

// File: hdl/mips_pipe_pkg.sv
`default_nettype none

`include "mips_macros.svh"

package mips_pipe_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // how imm16 is widened for execute
    typedef enum logic [1:0] {
        IMM_NONE,
        IMM_SIGN,
        IMM_ZERO,
        IMM_UPPER
    } imm_kind_t;

    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_BRANCH,
        TGT_JUMP
    } tgt_kind_t;

endpackage

`default_nettype wire

// File: hdl/mips_isa_pkg.sv
`default_nettype none

`include "mips_macros.svh"

package mips_isa_pkg;

    typedef logic [5:0] op_t;
    typedef logic [5:0] func_t;

    typedef struct packed {
        op_t                        op;
        logic [`REG_ADDR_W-1:0]     rs;
        logic [`REG_ADDR_W-1:0]     rt;
        logic [`REG_ADDR_W-1:0]     rd;
        logic [4:0]                 shamt;
        func_t                      funct;
    } r_fmt_t;

    typedef struct packed {
        op_t                        op;
        logic [`REG_ADDR_W-1:0]     rs;
        logic [`REG_ADDR_W-1:0]     rt;
        logic [15:0]                imm16;
    } i_fmt_t;

    typedef struct packed {
        op_t                        op;
        logic [25:0]                index26;
    } j_fmt_t;

    // one fetched word, viewed by format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [5:0] {
        ADD, ADDU, SUB, SUBU, SLT, SLTU,
        AND, LUI, OR, XOR,
        BEQ, BNE, BGEZ, BLTZ, BGEZAL, BLTZAL, BGTZ, BLEZ,
        J, JAL,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        ERET, MFC0, MTC0,
        ILLEGAL
    } mips_op_t;

endpackage

`default_nettype wire

// File: hdl/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// widths
`define WORD_W      32
`define REG_ADDR_W  5
`define LINK_REG    31

// primary opcodes
`define OP_RT       6'b000000
`define OP_BGEZ     6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_ERET     6'b010000
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011

// funct field of special opcode
`define F_ADD       6'b100000
`define F_ADDU      6'b100001
`define F_SUB       6'b100010
`define F_SUBU      6'b100011
`define F_SLT       6'b101010
`define F_SLTU      6'b101011

// rt field of regimm opcode
`define B_BLTZ      5'b00000
`define B_BGEZ      5'b00001
`define B_BLTZAL    5'b10000
`define B_BGEZAL    5'b10001

// rs field of cop0 opcode
`define C_MFC0      5'b00000
`define C_MTC0      5'b00100
`define C_ERET      5'b10000

`endif
